// ==== common/btc_defs.svh ====
//------------------------------
// Codeword length is bounded by the bit index width
// Alpha is coded in quarter steps, 0 stands for 1.0
//------------------------------

`ifndef BTC_DEFS_SVH
`define BTC_DEFS_SVH

// Channel LLR width, signed
`define BTC_LLR_W       5

// Extrinsic and a-priori width, signed
`define BTC_EXTR_W      6

// Extrinsic scale width
`define BTC_ALPHA_W     2

// Bit index, 32 bits per codeword at most
`define BTC_BIT_IDX_W   5

// Shortest codeword the sort unit accepts
`define BTC_MIN_CW_LEN  4

`endif

// ==== common/btc_spc_pkg.sv ====
//------------------------------
// Types of the SPC component-code engine
// Widths follow the defs header
//------------------------------

`default_nettype none

`include "btc_defs.svh"

package btc_spc_pkg;

  // Soft values
  typedef logic signed [`BTC_LLR_W-1:0]  llr_t;
  typedef logic signed [`BTC_EXTR_W-1:0] extr_t;
  // Reliability, saturated at 31
  typedef logic [`BTC_EXTR_W-2:0]        mag_t;
  // 0 is a scale of 1.0, else value/4
  typedef logic [`BTC_ALPHA_W-1:0]       alpha_t;
  typedef logic [`BTC_BIT_IDX_W-1:0]     bit_idx_t;

  // Codeword framing
  typedef struct packed {
    logic sop;
    logic eop;
  } strb_t;

  // One soft bit at the input
  typedef struct packed {
    strb_t strb;
    llr_t  llr;
    extr_t lextr;
  } in_word_t;

  // Ping-pong a-priori memory address
  typedef struct packed {
    logic     bank;
    bit_idx_t idx;
  } mem_addr_t;

  // Sort result of one codeword
  typedef struct packed {
    mag_t     min0;
    mag_t     min1;
    bit_idx_t min0_idx;
    logic     prod_sign;
    bit_idx_t last_idx;
    logic     bank;
  } sort_res_t;

  // One decoded bit at the output
  typedef struct packed {
    strb_t strb;
    extr_t lextr;
    logic  bitdat;
    logic  biterr;
    logic  decfail;
  } out_word_t;

endpackage

`default_nettype wire

// ==== design/btc_lapri_mem.sv ====
//------------------------------
// Two banks of 32 a-priori values
// Read data one cycle after the address, old data on collision
//------------------------------

`default_nettype none

module btc_lapri_mem (
  input  logic                   iclk,
  input  logic                   iclkena,
  input  logic                   write,
  input  btc_spc_pkg::mem_addr_t waddr,
  input  btc_spc_pkg::extr_t     wdat,
  input  btc_spc_pkg::mem_addr_t raddr,
  output btc_spc_pkg::extr_t     rdat
);

  import btc_spc_pkg::*;

  // Bank bit plus bit index
  localparam int depth = 2**$bits(mem_addr_t);

  // Storage, bank in the address MSB
  extr_t mem [depth];

  //------------------------------
  // Write port and registered read
  //------------------------------

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      if (write) begin
        mem[waddr] <= wdat;
      end
      // Read stalls with the clock enable
      rdat <= mem[raddr];
    end
  end

endmodule

`default_nettype wire

// ==== design/btc_hd_fifo.sv ====
//------------------------------
// Channel hard decisions of up to two codewords
// pop_bit valid one cycle after pop, no guard on misuse
//------------------------------

`default_nettype none

`include "btc_defs.svh"

module btc_hd_fifo (
  input  logic iclk,
  input  logic ireset,
  input  logic iclkena,
  input  logic clear,
  input  logic push,
  input  logic push_bit,
  input  logic pop,
  output logic pop_bit
);

  // Two codewords of the longest length
  localparam int ptr_w = `BTC_BIT_IDX_W + 1;
  localparam int depth = 2**ptr_w;

  logic [depth-1:0] mem;
  logic [ptr_w-1:0] wptr;
  logic [ptr_w-1:0] rptr;
  // Fill level, one bit wider than the pointers
  logic [ptr_w:0]   cnt;
  logic             full;
  logic             empty;

  assign full  = (cnt == (ptr_w+1)'(depth));
  assign empty = (cnt == '0);

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      wptr <= '0;
      rptr <= '0;
      cnt  <= '0;
    end else if (iclkena) begin
      if (clear) begin
        wptr <= '0;
        rptr <= '0;
        cnt  <= '0;
      end else begin
        if (push) begin
          wptr <= wptr + 1'b1;
        end
        if (pop) begin
          rptr <= rptr + 1'b1;
        end
        case ({push, pop})
          2'b10:   cnt <= cnt + 1'b1;
          2'b01:   cnt <= cnt - 1'b1;
          default: cnt <= cnt;
        endcase
      end
    end
  end

  // Bit storage and read register
  always_ff @(posedge iclk) begin
    if (iclkena) begin
      if (push) begin
        mem[wptr] <= push_bit;
      end
      if (pop) begin
        pop_bit <= mem[rptr];
      end
    end
  end

  // Sort side never runs more than two codewords ahead
  assert property (@(posedge iclk) disable iff (ireset)
    (iclkena && !clear && push) |-> !full)
    else $error("hd FIFO overflow");

  // Decoder pops only bits that were pushed
  assert property (@(posedge iclk) disable iff (ireset)
    (iclkena && !clear && pop) |-> !empty)
    else $error("hd FIFO underflow");

endmodule

`default_nettype wire

// ==== design/btc_spc_sort.sv ====
//------------------------------
// Words outside a codeword are dropped until the next sop
// eop to sort_done is one cycle, bank toggles per codeword
//------------------------------

`default_nettype none

`include "btc_defs.svh"

module btc_spc_sort (
  input  logic                   iclk,
  input  logic                   ireset,
  input  logic                   iclkena,
  input  logic                   istart,
  input  btc_spc_pkg::alpha_t    alpha,
  input  logic                   ival,
  input  btc_spc_pkg::in_word_t  in_word,
  output logic                   lapri_write,
  output btc_spc_pkg::mem_addr_t lapri_waddr,
  output btc_spc_pkg::extr_t     lapri,
  output logic                   hd_push,
  output logic                   hd_bit,
  output logic                   sort_done,
  output btc_spc_pkg::sort_res_t sort_res
);

  import btc_spc_pkg::*;

  // Internal sum width, room for LLR plus scaled extrinsic
  localparam int sum_w   = `BTC_EXTR_W + 2;
  localparam int sat_lim = 2**(`BTC_EXTR_W-1) - 1;

  // Codeword framing state
  logic              in_cw;
  bit_idx_t          cnt;
  logic              bank;
  // Running search over the codeword
  mag_t              min0;
  mag_t              min1;
  bit_idx_t          min0_idx;
  logic              prod_sign;
  // Current word
  logic              acc;
  bit_idx_t          cur_idx;
  logic signed [sum_w-1:0] ext_prod;
  logic signed [sum_w-1:0] ext_scaled;
  logic signed [sum_w-1:0] apri_sum;
  extr_t             apri;
  mag_t              apri_mag;
  // Search state after this word
  mag_t              nxt_min0;
  mag_t              nxt_min1;
  bit_idx_t          nxt_min0_idx;
  logic              nxt_sign;

  //------------------------------
  // A-priori value
  //------------------------------

  // Accepted when it opens or continues a codeword
  assign acc     = ival & (in_word.strb.sop | in_cw) & ~istart;
  assign cur_idx = in_word.strb.sop ? '0 : cnt;

  // Scale by alpha/4, alpha of 0 passes through
  assign ext_prod   = $signed(in_word.lextr) * $signed({1'b0, alpha});
  assign ext_scaled = (alpha == '0) ? sum_w'($signed(in_word.lextr)) : (ext_prod >>> 2);
  assign apri_sum   = $signed(in_word.llr) + ext_scaled;

  always_comb begin
    // Symmetric saturation to +-31
    if (apri_sum > sat_lim) begin
      apri = extr_t'(sat_lim);
    end else if (apri_sum < -sat_lim) begin
      apri = extr_t'(-sat_lim);
    end else begin
      apri = extr_t'(apri_sum);
    end
  end

  assign apri_mag = apri[`BTC_EXTR_W-1] ? mag_t'(-apri) : mag_t'(apri);

  //------------------------------
  // Two-minimum search
  //------------------------------

  always_comb begin
    // sop restarts from the largest magnitude
    nxt_min0     = in_word.strb.sop ? '1 : min0;
    nxt_min1     = in_word.strb.sop ? '1 : min1;
    nxt_min0_idx = in_word.strb.sop ? '0 : min0_idx;
    nxt_sign     = (in_word.strb.sop ? 1'b0 : prod_sign) ^ apri[`BTC_EXTR_W-1];
    if (apri_mag < nxt_min0) begin
      nxt_min1     = nxt_min0;
      nxt_min0     = apri_mag;
      nxt_min0_idx = cur_idx;
    end else if (apri_mag < nxt_min1) begin
      nxt_min1 = apri_mag;
    end
  end

  // Memory and FIFO written straight from the input word
  assign lapri_write = acc;
  assign lapri_waddr = '{bank: bank, idx: cur_idx};
  assign lapri       = apri;
  assign hd_push     = acc;
  assign hd_bit      = in_word.llr[`BTC_LLR_W-1];

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      in_cw     <= 1'b0;
      cnt       <= '0;
      bank      <= 1'b0;
      sort_done <= 1'b0;
    end else if (iclkena) begin
      if (istart) begin
        in_cw     <= 1'b0;
        cnt       <= '0;
        bank      <= 1'b0;
        sort_done <= 1'b0;
      end else begin
        sort_done <= acc & in_word.strb.eop;
        if (acc) begin
          in_cw <= ~in_word.strb.eop;
          cnt   <= cur_idx + 1'b1;
          // Next codeword goes to the other bank
          if (in_word.strb.eop) begin
            bank <= ~bank;
          end
        end
      end
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena && acc) begin
      min0      <= nxt_min0;
      min1      <= nxt_min1;
      min0_idx  <= nxt_min0_idx;
      prod_sign <= nxt_sign;
      if (in_word.strb.eop) begin
        sort_res <= '{min0: nxt_min0, min1: nxt_min1, min0_idx: nxt_min0_idx,
                      prod_sign: nxt_sign, last_idx: cur_idx, bank: bank};
      end
    end
  end

  // Codeword not shorter than the minimum length
  assert property (@(posedge iclk) disable iff (ireset)
    (iclkena && acc && in_word.strb.eop) |-> (cur_idx >= `BTC_MIN_CW_LEN - 1))
    else $error("codeword shorter than minimum length");

  // No word outside a codeword except the opening sop
  assert property (@(posedge iclk) disable iff (ireset)
    (iclkena && ival && !istart && !in_cw) |-> in_word.strb.sop)
    else $error("codeword without sop");

endmodule

`default_nettype wire

// ==== design/btc_spc_decode.sv ====
//------------------------------
// One bit per cycle, sort_done to first oval is 4 cycles
// Next sort_done accepted on the last read of a pass at the earliest
//------------------------------

`default_nettype none

module btc_spc_decode (
  input  logic                   iclk,
  input  logic                   ireset,
  input  logic                   iclkena,
  input  logic                   istart,
  input  logic                   sort_done,
  input  btc_spc_pkg::sort_res_t sort_res,
  input  btc_spc_pkg::extr_t     lapri,
  input  logic                   hd_bit,
  output btc_spc_pkg::mem_addr_t lapri_raddr,
  output logic                   hd_pop,
  output logic                   oval,
  output btc_spc_pkg::out_word_t out_word
);

  import btc_spc_pkg::*;

  // Per-bit controls, travel with the bit down the pipe
  typedef struct packed {
    strb_t strb;
    mag_t  mag;
    logic  prod_sign;
  } bit_ctl_t;

  // Captured codeword result
  sort_res_t res;
  // Read pass
  logic      rd_active;
  bit_idx_t  rd_idx;
  logic      rd_last;
  bit_ctl_t  rd_ctl;
  // Stage 1 memory data, stage 2 FIFO data
  logic      s1_val;
  bit_ctl_t  s1_ctl;
  logic      s2_val;
  bit_ctl_t  s2_ctl;
  extr_t     s2_lapri;
  // Min-sum result
  logic      ext_sign;
  extr_t     ext_val;
  logic signed [$bits(extr_t):0] soft_sum;

  //------------------------------
  // Read pass over the codeword
  //------------------------------

  assign rd_last     = (rd_idx == res.last_idx);
  assign lapri_raddr = '{bank: res.bank, idx: rd_idx};

  always_comb begin
    rd_ctl.strb.sop  = (rd_idx == '0);
    rd_ctl.strb.eop  = rd_last;
    // Least reliable bit gets the second minimum
    rd_ctl.mag       = (rd_idx == res.min0_idx) ? res.min1 : res.min0;
    rd_ctl.prod_sign = res.prod_sign;
  end

  // Pop alongside the memory data
  assign hd_pop = s1_val;

  //------------------------------
  // Min-sum SPC rule
  //------------------------------

  assign ext_sign = s2_ctl.prod_sign ^ s2_lapri[$bits(extr_t)-1];
  assign ext_val  = ext_sign ? -(extr_t'(s2_ctl.mag)) : extr_t'(s2_ctl.mag);
  // Full width, no saturation before the decision
  assign soft_sum = s2_lapri + ext_val;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      rd_active <= 1'b0;
      rd_idx    <= '0;
      s1_val    <= 1'b0;
      s2_val    <= 1'b0;
      oval      <= 1'b0;
    end else if (iclkena) begin
      if (istart) begin
        rd_active <= 1'b0;
        rd_idx    <= '0;
        s1_val    <= 1'b0;
        s2_val    <= 1'b0;
        oval      <= 1'b0;
      end else begin
        if (sort_done) begin
          rd_active <= 1'b1;
          rd_idx    <= '0;
        end else if (rd_active) begin
          rd_active <= ~rd_last;
          rd_idx    <= rd_idx + 1'b1;
        end
        s1_val <= rd_active;
        s2_val <= s1_val;
        oval   <= s2_val;
      end
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      if (sort_done) begin
        res <= sort_res;
      end
      s1_ctl   <= rd_ctl;
      s2_ctl   <= s1_ctl;
      s2_lapri <= lapri;
      // Output word
      out_word.strb    <= s2_ctl.strb;
      out_word.lextr   <= ext_val;
      out_word.bitdat  <= soft_sum[$bits(extr_t)];
      out_word.biterr  <= soft_sum[$bits(extr_t)] ^ hd_bit;
      out_word.decfail <= s2_ctl.prod_sign;
    end
  end

  // Sort unit at most one codeword ahead of the read pass
  assert property (@(posedge iclk) disable iff (ireset)
    (iclkena && !istart && sort_done) |-> (!rd_active || rd_last))
    else $error("sort_done during a read pass");

endmodule

`default_nettype wire

// ==== design/btc_spc_engine.sv ====
//------------------------------
// No back-pressure, first oval 5 cycles after eop
// Next codeword only once the previous output has begun
//------------------------------

`default_nettype none

module btc_spc_engine (
  input  logic                   iclk,
  input  logic                   ireset,
  input  logic                   iclkena,
  input  logic                   istart,
  input  btc_spc_pkg::alpha_t    alpha,
  input  logic                   ival,
  input  btc_spc_pkg::in_word_t  in_word,
  output logic                   oval,
  output btc_spc_pkg::out_word_t out_word
);

  import btc_spc_pkg::*;

  // Sort to memory and FIFO
  logic      lapri_write;
  mem_addr_t lapri_waddr;
  extr_t     lapri_wdat;
  logic      hd_push;
  logic      hd_push_bit;
  // Sort to decode
  logic      sort_done;
  sort_res_t sort_res;
  // Decode reads
  mem_addr_t lapri_raddr;
  extr_t     lapri_rdat;
  logic      hd_pop;
  logic      hd_pop_bit;

  btc_spc_sort sort_unit (
    .iclk(iclk), .ireset(ireset), .iclkena(iclkena), .istart(istart),
    .alpha(alpha), .ival(ival), .in_word(in_word),
    .lapri_write(lapri_write), .lapri_waddr(lapri_waddr), .lapri(lapri_wdat),
    .hd_push(hd_push), .hd_bit(hd_push_bit),
    .sort_done(sort_done), .sort_res(sort_res)
  );

  btc_lapri_mem lapri_mem (
    .iclk(iclk), .iclkena(iclkena),
    .write(lapri_write), .waddr(lapri_waddr), .wdat(lapri_wdat),
    .raddr(lapri_raddr), .rdat(lapri_rdat)
  );

  // Cleared with the engine on istart
  btc_hd_fifo hd_fifo (
    .iclk(iclk), .ireset(ireset), .iclkena(iclkena), .clear(istart),
    .push(hd_push), .push_bit(hd_push_bit), .pop(hd_pop), .pop_bit(hd_pop_bit)
  );

  btc_spc_decode spc_dec (
    .iclk(iclk), .ireset(ireset), .iclkena(iclkena), .istart(istart),
    .sort_done(sort_done), .sort_res(sort_res),
    .lapri(lapri_rdat), .hd_bit(hd_pop_bit),
    .lapri_raddr(lapri_raddr), .hd_pop(hd_pop),
    .oval(oval), .out_word(out_word)
  );

endmodule

`default_nettype wire

// ==== dv/btc_spc_engine_tb.sv ====
//------------------------------
// Random codewords of 4 to 32 bits against a queue model of the min-sum SPC rule
// eop held back until the previous read pass can end, sop until its output begins
//------------------------------

`default_nettype none

module btc_spc_engine_tb;

  import btc_spc_pkg::*;

  localparam int n_cw        = 300;
  localparam int cyc_per_cw  = 80;
  localparam int max_cycles  = n_cw * cyc_per_cw;
  // Enabled edges from eop to the first output word
  localparam int out_start   = 5;
  // Longest wait for the last codeword, stalls included
  localparam int drain_limit = 4 * (out_start + 32);

  logic      iclk = 1'b0;
  logic      ireset;
  logic      iclkena;
  logic      istart;
  alpha_t    alpha;
  logic      ival;
  in_word_t  in_word;
  logic      oval;
  out_word_t out_word;

  // Current codeword
  int        cw_llr [32];
  int        cw_ext [32];
  int        cw_len;
  int        cw_alpha;
  // Model results and run state
  out_word_t exp_q [$];
  logic      parity_q [$];
  logic      cur_parity;
  int        since_eop;
  int        prev_len;
  int        cycles;
  int        drained;
  int        n_exp;
  int        n_out;
  int        seed_val;
  logic      acc;

  btc_spc_engine DUT (
    .iclk(iclk), .ireset(ireset), .iclkena(iclkena), .istart(istart),
    .alpha(alpha), .ival(ival), .in_word(in_word),
    .oval(oval), .out_word(out_word)
  );

  always #2 iclk = ~iclk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_word(input out_word_t got, input out_word_t exp);
    if (got !== exp) begin
      abort_run($sformatf("** Error: out_word got %h expected %h at output word %0d",
                          got, exp, n_out));
    end
  endtask

  task automatic check_decfail(input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("** Error: out_word.decfail got %h expected %h at output word %0d",
                          got, exp, n_out));
    end
  endtask

  // LLR plus alpha-scaled extrinsic, clipped to +-31
  function automatic int apri_model(input int llr, input int ext, input int a);
    int sc;
    int sum;
    sc  = (a == 0) ? ext : ((ext * a) >>> 2);
    sum = llr + sc;
    if (sum > 31) sum = 31;
    if (sum < -31) sum = -31;
    return sum;
  endfunction

  //------------------------------
  // Reference model
  //------------------------------

  task automatic build_expected();
    int        ap [32];
    int        mag [32];
    int        min0;
    int        min1;
    int        idx;
    int        m;
    int        ext;
    logic      par;
    out_word_t w;
    min0 = 32;
    min1 = 32;
    idx  = 0;
    par  = 1'b0;
    for (int i = 0; i < cw_len; i++) begin
      ap[i]  = apri_model(cw_llr[i], cw_ext[i], cw_alpha);
      mag[i] = (ap[i] < 0) ? -ap[i] : ap[i];
      par    = par ^ (ap[i] < 0);
      // First position of the smallest magnitude
      if (mag[i] < min0) begin
        min0 = mag[i];
        idx  = i;
      end
    end
    for (int i = 0; i < cw_len; i++) begin
      if (i != idx && mag[i] < min1) min1 = mag[i];
    end
    for (int i = 0; i < cw_len; i++) begin
      m         = (i == idx) ? min1 : min0;
      ext       = (par ^ (ap[i] < 0)) ? -m : m;
      w.strb    = '{sop: (i == 0), eop: (i == cw_len - 1)};
      w.lextr   = extr_t'(ext);
      w.bitdat  = (ap[i] + ext) < 0;
      w.biterr  = w.bitdat ^ (cw_llr[i] < 0);
      w.decfail = par;
      exp_q.push_back(w);
    end
    parity_q.push_back(par);
    n_exp += cw_len;
  endtask

  // Output word of the edge just passed
  task automatic collect_output();
    out_word_t exp;
    if (oval) begin
      if (exp_q.size() == 0) abort_run("oval high while no codeword is pending");
      exp = exp_q.pop_front();
      if (exp.strb.sop) cur_parity = parity_q.pop_front();
      check_decfail(out_word.decfail, cur_parity);
      check_word(out_word, exp);
      n_out++;
    end
  endtask

  //------------------------------
  // One clock, inputs set at the falling edge
  //------------------------------

  task automatic run_cycle(output logic accepted);
    @(negedge iclk);
    cycles++;
    if (cycles > max_cycles) abort_run("timeout, the run did not finish in time");
    accepted = iclkena & ival & ~istart;
    if (iclkena && istart) begin
      // Engine flushed, nothing pending may come out
      n_exp -= exp_q.size();
      exp_q.delete();
      parity_q.delete();
      since_eop = 1000;
      prev_len  = 0;
    end
    if (iclkena) begin
      collect_output();
      if (since_eop < 1000) since_eop++;
    end
    if (accepted && in_word.strb.eop) begin
      since_eop = 0;
      prev_len  = cw_len;
      build_expected();
    end
    iclkena = ($urandom_range(7, 0) != 0);
    ival    = 1'b0;
    istart  = 1'b0;
  endtask

  task automatic send_codeword();
    int   pos;
    int   abort_at;
    logic took;
    cw_len   = $urandom_range(32, 4);
    cw_alpha = $urandom_range(3, 0);
    alpha    = alpha_t'(cw_alpha);
    for (int i = 0; i < cw_len; i++) begin
      // Saturating corners now and then
      cw_llr[i] = ($urandom_range(7, 0) == 0) ? ($urandom_range(1, 0) ? -16 : 15)
                                              : $urandom_range(31, 0) - 16;
      cw_ext[i] = ($urandom_range(7, 0) == 0) ? ($urandom_range(1, 0) ? -32 : 31)
                                              : $urandom_range(63, 0) - 32;
    end
    abort_at = ($urandom_range(39, 0) == 0) ? $urandom_range(cw_len - 2, 1) : -1;
    pos = 0;
    while (pos < cw_len) begin
      if (pos == abort_at) begin
        ival    = 1'b0;
        istart  = 1'b1;
        iclkena = 1'b1;
        run_cycle(took);
        repeat (8) run_cycle(took);
        return;
      end
      in_word.strb  = '{sop: (pos == 0), eop: (pos == cw_len - 1)};
      in_word.llr   = llr_t'(cw_llr[pos]);
      in_word.lextr = extr_t'(cw_ext[pos]);
      ival = ($urandom_range(3, 0) != 0);
      // Wait for the previous output to begin
      if (pos == 0 && since_eop + 1 < out_start) ival = 1'b0;
      // Wait for the previous read pass to reach its last bit
      if (pos == cw_len - 1 && since_eop + 1 < prev_len) ival = 1'b0;
      run_cycle(took);
      if (took) pos++;
    end
  endtask

  initial begin
    seed_val  = $urandom(32'h2a7177aa);
    ireset    = 1'b1;
    iclkena   = 1'b1;
    istart    = 1'b0;
    alpha     = '0;
    ival      = 1'b0;
    in_word   = '0;
    since_eop = 1000;
    prev_len  = 0;
    cycles    = 0;
    drained   = 0;
    n_exp     = 0;
    n_out     = 0;
    cur_parity = 1'b0;
    repeat (4) begin
      @(negedge iclk);
      if (oval !== 1'b0) abort_run("oval not low during reset");
    end
    ireset = 1'b0;
    for (int n = 0; n < n_cw; n++) begin
      send_codeword();
    end
    // Drain, then look for stray words
    while (exp_q.size() != 0 && drained < drain_limit) begin
      run_cycle(acc);
      drained++;
    end
    repeat (16) run_cycle(acc);
    if (n_out != n_exp || n_out == 0) begin
      abort_run($sformatf("output word count %0d does not match expected %0d", n_out, n_exp));
    end else begin
      $display("Simulation passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+common
common/btc_spc_pkg.sv
design/btc_lapri_mem.sv
design/btc_hd_fifo.sv
design/btc_spc_sort.sv
design/btc_spc_decode.sv
design/btc_spc_engine.sv
dv/btc_spc_engine_tb.sv

// ==== Bender.yml ====
package:
  name: btc_spc_engine

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/btc_spc_pkg.sv
      - design/btc_lapri_mem.sv
      - design/btc_hd_fifo.sv
      - design/btc_spc_sort.sv
      - design/btc_spc_decode.sv
      - design/btc_spc_engine.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - dv/btc_spc_engine_tb.sv
